// File: hw/stream_pkg.sv
// stream word, strobe, offset and beat types, imported by every block of the realign datapath.

package stream_pkg;

  // ########################################
  // bus geometry
  // ########################################

  // bus word width in bits.
  localparam int unsigned DATA_WIDTH     = 32;
  // bytes carried by one word.
  localparam int unsigned BYTES_PER_WORD = DATA_WIDTH / 8;
  // enough bits to name a byte inside a word.
  localparam int unsigned OFFSET_WIDTH   = $clog2(BYTES_PER_WORD);

  typedef logic [DATA_WIDTH-1:0]     data_t;
  typedef logic [BYTES_PER_WORD-1:0] strb_t;
  typedef logic [OFFSET_WIDTH-1:0]   offset_t;

  // up to 16 lanes.
  typedef logic [3:0] lane_id_t;

  // ########################################
  // beats
  // ########################################

  // one stream beat, ready runs the other way.
  typedef struct packed {
    logic  valid;
    data_t data;
  } stream_beat_t;

  // merged output beat, tagged with its source lane.
  typedef struct packed {
    logic     valid;
    lane_id_t lane;
    data_t    data;
  } out_beat_t;

endpackage

// File: hw/realign_pkg.sv
// transfer command, per-lane realign control flags and lane FSM state, used by generator and lanes.

package realign_pkg;

  import stream_pkg::*;

  // ########################################
  // commands
  // ########################################

  // output word count of one transfer.
  typedef logic [7:0] word_count_t;

  // one transfer request for a lane.
  // words counts output words, never zero.
  typedef struct packed {
    offset_t     offset;
    word_count_t words;
  } realign_cmd_t;

  // ########################################
  // lane control
  // ########################################

  // flags driven from the generator into a lane.
  typedef struct packed {
    // lane holds a running transfer.
    logic enable;
    // stored offset is nonzero.
    logic realign;
    // current input word opens the transfer.
    logic first;
    // current input word closes the transfer.
    logic last;
  } ctrl_realign_t;

  // per-lane sequencing state.
  typedef enum logic {
    LANE_IDLE,
    LANE_RUN
  } lane_state_e;

endpackage

// File: hw/realign_ctrl_gen.sv
// control generator for all lanes: takes commands, counts input words, drives realign flags.

`timescale 1ns/100ps

module realign_ctrl_gen
  import stream_pkg::*;
  import realign_pkg::*;
#(
  parameter int unsigned NUM_LANES = 4
) (
  input  logic                           clk_gated,
  input  logic                           rst_ni,
  input  logic                           clear_i,
  // command side.
  input  logic          [NUM_LANES-1:0]  cmd_valid_i,
  input  realign_cmd_t  [NUM_LANES-1:0]  cmd_i,
  output logic          [NUM_LANES-1:0]  cmd_ready_o,
  // observed input handshake.
  input  logic          [NUM_LANES-1:0]  in_valid_i,
  input  logic          [NUM_LANES-1:0]  in_ready_i,
  // lane control.
  output ctrl_realign_t [NUM_LANES-1:0]  ctrl_o,
  output strb_t         [NUM_LANES-1:0]  first_strb_o
);

  for (genvar g = 0; g < NUM_LANES; g++) begin : gen_lane

    lane_state_e  state_q;
    realign_cmd_t cmd_q;
    // input words still to come, minus one.
    word_count_t  remain_q;
    logic         first_q;
    logic         busy;
    logic         in_xfer;
    logic         last;

    assign busy    = (state_q == LANE_RUN);
    assign in_xfer = busy & in_valid_i[g] & in_ready_i[g];
    // counter hits zero on the closing input word.
    assign last    = busy & (remain_q == '0);

    // ########################################
    // lane sequencing
    // ########################################

    always_ff @(posedge clk_gated or negedge rst_ni) begin
      if (!rst_ni) begin
        state_q  <= LANE_IDLE;
        cmd_q    <= '0;
        remain_q <= '0;
        first_q  <= 1'b0;
      end else if (clear_i) begin
        state_q  <= LANE_IDLE;
        cmd_q    <= '0;
        remain_q <= '0;
        first_q  <= 1'b0;
      end else begin
        case (state_q)
          LANE_IDLE: begin
            if (cmd_valid_i[g]) begin
              state_q  <= LANE_RUN;
              cmd_q    <= cmd_i[g];
              first_q  <= 1'b1;
              // misaligned transfers eat one extra word.
              remain_q <= cmd_i[g].words - word_count_t'(cmd_i[g].offset == '0);
            end
          end
          LANE_RUN: begin
            if (in_xfer) begin
              first_q <= 1'b0;
              if (last) begin
                state_q <= LANE_IDLE;
              end else begin
                remain_q <= remain_q - word_count_t'(1);
              end
            end
          end
          default: state_q <= LANE_IDLE;
        endcase
      end
    end

    // ########################################
    // outputs
    // ########################################

    // ready exactly while idle.
    assign cmd_ready_o[g] = ~busy;

    assign ctrl_o[g].enable  = busy;
    assign ctrl_o[g].realign = busy & (cmd_q.offset != '0);
    assign ctrl_o[g].first   = first_q;
    assign ctrl_o[g].last    = last;

    // bytes at or above the offset.
    assign first_strb_o[g] = strb_t'('1) << cmd_q.offset;

  end

endmodule

// File: hw/source_realign.sv
// one realign lane: merges consecutive input words into words shifted by the stored byte offset.

`timescale 1ns/100ps

module source_realign
  import stream_pkg::*;
  import realign_pkg::*;
(
  input  logic          clk_gated,
  input  logic          rst_ni,
  input  logic          clear_i,
  input  ctrl_realign_t ctrl_i,
  input  strb_t         first_strb_i,
  // raw aligned words from memory.
  input  stream_beat_t  in_i,
  output logic          in_ready_o,
  // realigned words to the merger.
  output stream_beat_t  out_o,
  input  logic          out_ready_i
);

  // byte rotation, 0 up to a full word.
  typedef logic [OFFSET_WIDTH:0] rot_t;

  rot_t  rot_d;
  rot_t  rot_q;
  rot_t  rot_inv_q;
  data_t prev_q;
  logic  absorb;
  logic  in_xfer;
  logic  do_merge;

  // ########################################
  // rotation from first-word strobe
  // ########################################

  // popcount of the strobe.
  always_comb begin
    rot_d = '0;
    for (int i = 0; i < BYTES_PER_WORD; i++) begin
      rot_d = rot_d + rot_t'(first_strb_i[i]);
    end
  end

  // captured while the opening word is pending.
  always_ff @(posedge clk_gated or negedge rst_ni) begin
    if (!rst_ni) begin
      rot_q     <= '0;
      rot_inv_q <= '0;
    end else if (clear_i) begin
      rot_q     <= '0;
      rot_inv_q <= '0;
    end else if (ctrl_i.first) begin
      rot_q     <= rot_d;
      rot_inv_q <= rot_t'(BYTES_PER_WORD) - rot_d;
    end
  end

  // ########################################
  // previous word and handshake
  // ########################################

  // first word of a misaligned transfer is swallowed.
  assign absorb  = ctrl_i.first & ctrl_i.realign;
  assign in_xfer = in_i.valid & in_ready_o;

  always_ff @(posedge clk_gated or negedge rst_ni) begin
    if (!rst_ni) begin
      prev_q <= '0;
    end else if (clear_i) begin
      prev_q <= '0;
    end else if (in_xfer) begin
      prev_q <= in_i.data;
    end
  end

  // forced ready while absorbing, else follow the merger.
  assign in_ready_o = ctrl_i.enable & (absorb | out_ready_i);
  assign out_o.valid = ctrl_i.enable & in_i.valid & ~absorb;

  // ########################################
  // data path
  // ########################################

  // no merge for zero or full-word rotation.
  assign do_merge = ctrl_i.realign & (rot_q != '0) & (rot_q != rot_t'(BYTES_PER_WORD));

  // current word up by rot bytes, previous down by the rest.
  assign out_o.data = do_merge ?
                      ((in_i.data << {rot_q, 3'b000}) | (prev_q >> {rot_inv_q, 3'b000})) :
                      in_i.data;

endmodule

// File: hw/lane_merge.sv
// round-robin merger draining all lane streams into one registered, lane-tagged output stream.

`timescale 1ns/100ps

module lane_merge
  import stream_pkg::*;
#(
  parameter int unsigned NUM_LANES = 4
) (
  input  logic                          clk_gated,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  // lane side.
  input  stream_beat_t [NUM_LANES-1:0]  lane_i,
  output logic         [NUM_LANES-1:0]  lane_ready_o,
  // merged output.
  output out_beat_t                     out_o,
  input  logic                          out_ready_i
);

  out_beat_t out_q;
  lane_id_t  ptr_q;
  lane_id_t  sel;
  data_t     sel_data;
  logic      found;
  logic      take;

  // output slot free or draining this cycle.
  assign take = ~out_q.valid | out_ready_i;

  // ########################################
  // arbitration
  // ########################################

  // lanes from the pointer upward first, then wrap.
  always_comb begin
    found    = 1'b0;
    sel      = '0;
    sel_data = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      if (!found && lane_i[i].valid && (lane_id_t'(i) >= ptr_q)) begin
        found    = 1'b1;
        sel      = lane_id_t'(i);
        sel_data = lane_i[i].data;
      end
    end
    for (int i = 0; i < NUM_LANES; i++) begin
      if (!found && lane_i[i].valid) begin
        found    = 1'b1;
        sel      = lane_id_t'(i);
        sel_data = lane_i[i].data;
      end
    end
  end

  // ready only to the granted lane.
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_ready_o[i] = take & found & (sel == lane_id_t'(i));
    end
  end

  // ########################################
  // output register
  // ########################################

  always_ff @(posedge clk_gated or negedge rst_ni) begin
    if (!rst_ni) begin
      out_q <= '0;
      ptr_q <= '0;
    end else if (clear_i) begin
      out_q <= '0;
      ptr_q <= '0;
    end else if (take) begin
      out_q.valid <= found;
      if (found) begin
        out_q.lane <= sel;
        out_q.data <= sel_data;
        // next search starts after the winner.
        ptr_q      <= (sel == lane_id_t'(NUM_LANES - 1)) ? '0 : sel + lane_id_t'(1);
      end
    end
  end

  assign out_o = out_q;

endmodule

// File: hw/realign_top.sv
// realign source top level: control generator, one realign lane per stream and the output merger.

`timescale 1ns/100ps

module realign_top
  import stream_pkg::*;
  import realign_pkg::*;
#(
  parameter int unsigned NUM_LANES = 4
) (
  input  logic                          clk_gated,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  // commands.
  input  logic         [NUM_LANES-1:0]  cmd_valid_i,
  input  realign_cmd_t [NUM_LANES-1:0]  cmd_i,
  output logic         [NUM_LANES-1:0]  cmd_ready_o,
  // raw memory streams.
  input  stream_beat_t [NUM_LANES-1:0]  in_i,
  output logic         [NUM_LANES-1:0]  in_ready_o,
  // merged output.
  output out_beat_t                     out_o,
  input  logic                          out_ready_i
);

  ctrl_realign_t [NUM_LANES-1:0] ctrl;
  strb_t         [NUM_LANES-1:0] first_strb;
  stream_beat_t  [NUM_LANES-1:0] lane_beat;
  logic          [NUM_LANES-1:0] lane_ready;
  logic          [NUM_LANES-1:0] in_valid;

  // ########################################
  // shared sequencer
  // ########################################

  realign_ctrl_gen #(
    .NUM_LANES (NUM_LANES)
  ) u_ctrl_gen (
    .clk_gated    (clk_gated),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_i        (cmd_i),
    .cmd_ready_o  (cmd_ready_o),
    .in_valid_i   (in_valid),
    .in_ready_i   (in_ready_o),
    .ctrl_o       (ctrl),
    .first_strb_o (first_strb)
  );

  // ########################################
  // lanes
  // ########################################

  for (genvar g = 0; g < NUM_LANES; g++) begin : gen_lane
    // generator watches input valid.
    assign in_valid[g] = in_i[g].valid;

    source_realign u_lane (
      .clk_gated    (clk_gated),
      .rst_ni       (rst_ni),
      .clear_i      (clear_i),
      .ctrl_i       (ctrl[g]),
      .first_strb_i (first_strb[g]),
      .in_i         (in_i[g]),
      .in_ready_o   (in_ready_o[g]),
      .out_o        (lane_beat[g]),
      .out_ready_i  (lane_ready[g])
    );
  end

  // ########################################
  // output merge
  // ########################################

  lane_merge #(
    .NUM_LANES (NUM_LANES)
  ) u_merge (
    .clk_gated    (clk_gated),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .lane_i       (lane_beat),
    .lane_ready_o (lane_ready),
    .out_o        (out_o),
    .out_ready_i  (out_ready_i)
  );

endmodule

// File: bench/clk_gen.sv
// testbench clock and reset source, one free running clock and a counted active low reset.

`timescale 1ns/100ps

module clk_gen #(
  parameter int unsigned PERIOD_NS  = 40,
  parameter int unsigned RST_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_no
);

  // free running, 50 percent duty.
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release just after an edge.
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #2 rst_no = 1'b1;
  end

endmodule

// File: bench/tb_realign_top.sv
// testbench run by make test that checks realign_top output against a byte reference model.

`timescale 1ns/100ps

module tb_realign_top
  import stream_pkg::*;
  import realign_pkg::*;
;

  localparam int NUM_LANES     = 4;
  localparam int CLK_PERIOD_NS = 40;
  localparam int MAX_OUT       = 12;
  localparam int MAX_IN        = MAX_OUT + 1;
  localparam int MAX_BYTES     = 4 * MAX_IN;
  localparam int RAND_CMDS     = 6;
  // input words over all phases.
  localparam int TOTAL_WORDS   = 12 + 24 + NUM_LANES * RAND_CMDS * MAX_IN + 7 + 2 + 6;
  // 20 cycles per word plus margin.
  localparam int WATCH_CYCLES  = TOTAL_WORDS * 20 + 200;

  logic                          clk_gated;
  logic                          rst_ni;
  logic                          clear_i;
  logic         [NUM_LANES-1:0]  cmd_valid_i;
  realign_cmd_t [NUM_LANES-1:0]  cmd_i;
  logic         [NUM_LANES-1:0]  cmd_ready_o;
  stream_beat_t [NUM_LANES-1:0]  in_i;
  logic         [NUM_LANES-1:0]  in_ready_o;
  out_beat_t                     out_o;
  logic                          out_ready_i;
  // out_ready_i pattern selector.
  int                            ready_mode;
  data_t                         exp_q [NUM_LANES][$];

  clk_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RST_CYCLES(10)) u_clk_gen (
    .clk_o  (clk_gated),
    .rst_no (rst_ni)
  );

  realign_top #(.NUM_LANES(NUM_LANES)) u_realign_top (
    .clk_gated   (clk_gated),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .cmd_ready_o (cmd_ready_o),
    .in_i        (in_i),
    .in_ready_o  (in_ready_o),
    .out_o       (out_o),
    .out_ready_i (out_ready_i)
  );

  // ########################################
  // helpers and reference
  // ########################################

  task automatic fail_run(input string line);
    $display("%s", line);
    $display("Test failures found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_eq(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH at %0t: %s got %08h expected %08h", $time, what, got, exp));
    end
  endtask

  // bytes k to k+3 of little endian input words j and j+1.
  function automatic data_t ref_word(input logic [7:0] img [MAX_BYTES], input int k, input int j);
    data_t w;
    w = '0;
    for (int b = 0; b < 4; b++) begin
      w[8*b +: 8] = img[4*j + k + b];
    end
    return w;
  endfunction

  task automatic step();
    @(posedge clk_gated);
    #2;
  endtask

  // one command on lane l that stops after n_send input words.
  task automatic run_transfer(input int l, input int k, input int n_out, input int n_send,
                              input bit gaps, input bit poke);
    logic [7:0]   img [MAX_BYTES];
    data_t        words [MAX_IN];
    realign_cmd_t cmd;
    int           n_in;
    int           gap;
    n_in = (k == 0) ? n_out : n_out + 1;
    for (int i = 0; i < n_in; i++) begin
      words[i] = $urandom();
      for (int b = 0; b < 4; b++) begin
        img[4*i + b] = words[i][8*b +: 8];
      end
    end
    step();
    cmd.offset     = offset_t'(k);
    cmd.words      = word_count_t'(n_out);
    cmd_i[l]       = cmd;
    cmd_valid_i[l] = 1'b1;
    @(negedge clk_gated);
    while (!cmd_ready_o[l]) @(negedge clk_gated);
    for (int j = 0; j < n_out; j++) begin
      exp_q[l].push_back(ref_word(img, k, j));
    end
    step();
    // a busy lane must ignore this different command.
    cmd.offset     = offset_t'(k + 1);
    cmd.words      = word_count_t'(n_out + 2);
    cmd_i[l]       = cmd;
    cmd_valid_i[l] = poke;
    for (int i = 0; i < n_in && i < n_send; i++) begin
      cmd_valid_i[l] = poke && (i < n_in - 1);
      gap = gaps ? $urandom_range(0, 2) : 0;
      repeat (gap) step();
      in_i[l].valid = 1'b1;
      in_i[l].data  = words[i];
      @(negedge clk_gated);
      check_eq(data_t'(cmd_ready_o[l]), 0, $sformatf("lane %0d cmd_ready while busy", l));
      while (!in_ready_o[l]) begin
        @(negedge clk_gated);
        check_eq(data_t'(cmd_ready_o[l]), 0, $sformatf("lane %0d cmd_ready while busy", l));
      end
      step();
      in_i[l].valid = 1'b0;
    end
    if (n_send >= n_in) begin
      @(negedge clk_gated);
      check_eq(data_t'(cmd_ready_o[l]), 1, $sformatf("lane %0d cmd_ready after last word", l));
    end
  endtask

  task automatic random_commands(input int l);
    for (int c = 0; c < RAND_CMDS; c++) begin
      run_transfer(l, $urandom_range(0, 3), $urandom_range(1, MAX_OUT), MAX_IN, 1'b1, 1'b0);
    end
  endtask

  // waits until all lanes are idle and the output register is empty.
  task automatic drain();
    @(negedge clk_gated);
    ready_mode = 0;
    while (cmd_ready_o != '1 || out_o.valid) @(negedge clk_gated);
  endtask

  // ########################################
  // processes
  // ########################################

  initial begin : drive_out_ready
    forever begin
      step();
      case (ready_mode)
        0:       out_ready_i = 1'b1;
        1:       out_ready_i = ($urandom_range(0, 3) != 0);
        default: out_ready_i = 1'b0;
      endcase
    end
  end

  // pops the queue of the tagged lane per consumed beat.
  always @(negedge clk_gated) begin : compare_out
    int lane;
    lane = int'(out_o.lane);
    if (rst_ni && !clear_i && out_o.valid && out_ready_i) begin
      if (lane >= NUM_LANES || exp_q[lane].size() == 0) begin
        fail_run($sformatf("ERROR: unexpected output beat tagged lane %0d at %0t", lane, $time));
      end else begin
        check_eq(out_o.data, exp_q[lane].pop_front(), $sformatf("lane %0d output", lane));
      end
    end
  end

  initial begin : watchdog
    #(WATCH_CYCLES * CLK_PERIOD_NS);
    fail_run($sformatf("ERROR: run timed out after %0d cycles", WATCH_CYCLES));
  end

  initial begin : main_seq
    int pending;
    void'($urandom(32'h995ca34c));
    clear_i     = 1'b0;
    cmd_valid_i = '0;
    cmd_i       = '0;
    in_i        = '0;
    out_ready_i = 1'b1;
    ready_mode  = 0;
    @(posedge rst_ni);
    @(negedge clk_gated);
    check_eq(data_t'(out_o.valid), 0, "out valid after reset");
    check_eq(data_t'(cmd_ready_o), data_t'({NUM_LANES{1'b1}}), "cmd_ready after reset");
    // aligned pass through on one lane.
    run_transfer(0, 0, 4, MAX_IN, 1'b0, 1'b0);
    run_transfer(0, 0, 7, MAX_IN, 1'b0, 1'b0);
    run_transfer(0, 0, 1, MAX_IN, 1'b0, 1'b0);
    drain();
    // every misaligned offset.
    ready_mode = 1;
    for (int k = 1; k < 4; k++) begin
      run_transfer(1, k, 5 + k, MAX_IN, 1'b1, 1'b0);
    end
    drain();
    // all lanes at once with random gaps and back-pressure.
    ready_mode = 1;
    fork
      random_commands(0);
      random_commands(1);
      random_commands(2);
      random_commands(3);
    join
    drain();
    // command offered to a busy lane.
    ready_mode = 1;
    run_transfer(2, 1, 6, MAX_IN, 1'b1, 1'b1);
    drain();
    // clear with a beat parked in the output register.
    ready_mode = 2;
    run_transfer(0, 2, 6, 2, 1'b0, 1'b0);
    @(negedge clk_gated);
    check_eq(data_t'(out_o.valid), 1, "out valid before clear");
    check_eq(data_t'(cmd_ready_o[0]), 0, "lane 0 busy before clear");
    step();
    clear_i = 1'b1;
    step();
    clear_i = 1'b0;
    @(negedge clk_gated);
    check_eq(data_t'(out_o.valid), 0, "out valid after clear");
    check_eq(data_t'(cmd_ready_o), data_t'({NUM_LANES{1'b1}}), "cmd_ready after clear");
    exp_q[0].delete();
    ready_mode = 0;
    run_transfer(0, 3, 5, MAX_IN, 1'b0, 1'b0);
    drain();
    pending = 0;
    for (int l = 0; l < NUM_LANES; l++) begin
      pending += exp_q[l].size();
    end
    if (pending != 0) begin
      fail_run($sformatf("ERROR: %0d expected words never appeared on the output", pending));
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

// File: flist.f
hw/stream_pkg.sv
hw/realign_pkg.sv
hw/realign_ctrl_gen.sv
hw/source_realign.sv
hw/lane_merge.sv
hw/realign_top.sv
bench/clk_gen.sv
bench/tb_realign_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --timescale 1ns/100ps -j 0
TOP       := tb_realign_top
FLIST     := flist.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Test failures found
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
